/* mem_access_unit.f */
rv_mem_pkg.sv
rv_trap_pkg.sv
mem_req_if.sv
access_sequencer.sv
store_formatter.sv
load_extractor.sv
mem_access_unit.sv
tb_mem_access_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memory access unit testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

verilator --binary --timing --assert --top-module tb_mem_access_unit -f mem_access_unit.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output="$(./obj_dir/Vtb_mem_access_unit)"
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1

/* tb_mem_access_unit.sv */
`timescale 1ns/1ps

module tb_mem_access_unit;

	localparam int NUM_REQUESTS = 60;
	localparam int TIMEOUT_CYCLES = 40;
	localparam int DRIVE_DELAY = 2;
	localparam logic [31:0] LFSR_SEED = 32'h8258;

	logic clk;
	logic reset_internal;
	logic req_valid;
	logic req_load;
	logic req_unsigned;
	rv_mem_pkg::access_size_t req_size;
	rv_mem_pkg::word_t req_addr;
	rv_mem_pkg::word_t req_store_data;
	logic big_endian;
	logic busy;
	logic done;
	rv_mem_pkg::word_t load_data;
	logic excep;
	rv_trap_pkg::excep_code_t excep_code;
	rv_mem_pkg::word_t addr;
	rv_mem_pkg::access_size_t data_size;
	logic mem_read_enable;
	logic mem_write_enable;
	rv_mem_pkg::word_t mem_in;
	rv_mem_pkg::word_t mem_out;
	logic mem_ready;

	// Request currently on the bus, as the testbench issued it
	logic [31:0] cur_addr;
	rv_mem_pkg::access_size_t cur_size;
	logic cur_load;
	logic cur_unsigned;
	logic cur_be;
	logic [31:0] cur_data;
	logic [31:0] cur_word;

	logic [31:0] lfsr_state;
	logic [3:0] pending;
	logic accept_any;
	logic accept_aligned;
	logic accept_misaligned;
	logic enable_any;
	int error_count;
	int timeout_count;
	int issued;

	mem_access_unit u_mem_access_unit (
		.clk(clk),
		.reset_internal(reset_internal),
		.req_valid(req_valid),
		.req_load(req_load),
		.req_unsigned(req_unsigned),
		.req_size(req_size),
		.req_addr(req_addr),
		.req_store_data(req_store_data),
		.big_endian(big_endian),
		.busy(busy),
		.done(done),
		.load_data(load_data),
		.excep(excep),
		.excep_code(excep_code),
		.addr(addr),
		.data_size(data_size),
		.mem_read_enable(mem_read_enable),
		.mem_write_enable(mem_write_enable),
		.mem_in(mem_in),
		.mem_out(mem_out),
		.mem_ready(mem_ready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = 32'h0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_advance(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	function automatic logic is_misaligned(input logic [1:0] size, input logic [1:0] offset);
		return (size == 2'd2 && offset[0]) || (size == 2'd3 && offset != 2'd0);
	endfunction

	function automatic logic [31:0] expected_store(input logic [31:0] data,
		input logic [1:0] size, input logic be);
		logic [31:0] img;
		img = 32'h0;
		case (size)
			2'd1: img[31:24] = data[7:0];
			2'd2: img[31:16] = be ? {data[7:0], data[15:8]} : data[15:0];
			2'd3: img = be ? {data[7:0], data[15:8], data[23:16], data[31:24]} : data;
			default: img = 32'h0;
		endcase
		return img;
	endfunction

	function automatic logic [31:0] expected_load(input logic [31:0] word,
		input logic [1:0] offset, input logic [1:0] size, input logic uns, input logic be);
		logic [7:0] b;
		logic [15:0] h;
		logic [31:0] v;
		v = 32'h0;
		case (size)
			2'd1: begin
				case (offset)
					2'd0: b = word[31:24];
					2'd1: b = word[23:16];
					2'd2: b = word[15:8];
					default: b = word[7:0];
				endcase
				v = uns ? {24'h0, b} : {{24{b[7]}}, b};
			end
			2'd2: begin
				h = offset[1] ? word[15:0] : word[31:16];
				if (be)
					h = {h[7:0], h[15:8]};
				v = uns ? {16'h0, h} : {{16{h[15]}}, h};
			end
			2'd3: v = be ? {word[7:0], word[15:8], word[23:16], word[31:24]} : word;
			default: v = 32'h0;
		endcase
		return v;
	endfunction

	assign accept_any = req_valid && !busy;
	assign accept_misaligned = accept_any && is_misaligned(req_size, req_addr[1:0]);
	assign accept_aligned = accept_any && !is_misaligned(req_size, req_addr[1:0]);
	assign enable_any = mem_read_enable || mem_write_enable;

	// Accepted requests not yet completed
	always_ff @(posedge clk or posedge reset_internal) begin
		if (reset_internal)
			pending <= 4'd0;
		else
			pending <= pending + {3'b0, accept_any} - {3'b0, done || excep};
	end

	a_reset_idle: assert property (@(posedge clk) $fell(reset_internal) |->
		!busy && !done && !excep && !enable_any && load_data == 32'h0)
		else begin
			error_count = error_count + 1;
			$display("[ERROR] %0t: outputs not idle after reset", $time);
		end

	a_misaligned_trap: assert property (@(posedge clk) disable iff (reset_internal)
		accept_misaligned |=> excep && !enable_any
			&& excep_code == ($past(req_load) ? 4'd4 : 4'd6))
		else begin
			error_count = error_count + 1;
			$display("[ERROR] %0t: bad trap, excep=%b code=%0d", $time, excep, excep_code);
		end

	a_aligned_access: assert property (@(posedge clk) disable iff (reset_internal)
		accept_aligned |=> !excep
			&& ($past(req_load) ? (mem_read_enable && !mem_write_enable)
				: (mem_write_enable && !mem_read_enable)))
		else begin
			error_count = error_count + 1;
			$display("[ERROR] %0t: aligned request did not raise its enable", $time);
		end

	a_enable_source: assert property (@(posedge clk) disable iff (reset_internal)
		$rose(enable_any) |-> $past(accept_aligned))
		else begin
			error_count = error_count + 1;
			$display("[ERROR] %0t: enable rose without an aligned request", $time);
		end

	a_store_bus: assert property (@(posedge clk) disable iff (reset_internal)
		mem_write_enable |-> addr == cur_addr && data_size == cur_size
			&& mem_in == expected_store(cur_data, cur_size, cur_be))
		else begin
			error_count = error_count + 1;
			$display("[ERROR] %0t: store bus addr=%h size=%0d mem_in=%h", $time,
				addr, data_size, mem_in);
		end

	a_load_bus: assert property (@(posedge clk) disable iff (reset_internal)
		mem_read_enable |-> addr == cur_addr && data_size == cur_size)
		else begin
			error_count = error_count + 1;
			$display("[ERROR] %0t: load bus addr=%h size=%0d", $time, addr, data_size);
		end

	a_load_result: assert property (@(posedge clk) disable iff (reset_internal)
		(done && cur_load) |-> load_data
			== expected_load(cur_word, cur_addr[1:0], cur_size, cur_unsigned, cur_be))
		else begin
			error_count = error_count + 1;
			$display("[ERROR] %0t: load_data=%h for word %h", $time, load_data, cur_word);
		end

	a_load_hold: assert property (@(posedge clk) disable iff (reset_internal)
		!(mem_read_enable && mem_ready) |=> $stable(load_data))
		else begin
			error_count = error_count + 1;
			$display("[ERROR] %0t: load_data changed without a read", $time);
		end

	a_hold_while_waiting: assert property (@(posedge clk) disable iff (reset_internal)
		(enable_any && !mem_ready) |=> $stable(addr) && $stable(data_size)
			&& $stable(mem_read_enable) && $stable(mem_write_enable) && $stable(mem_in))
		else begin
			error_count = error_count + 1;
			$display("[ERROR] %0t: bus moved during a wait state", $time);
		end

	a_done_after_ready: assert property (@(posedge clk) disable iff (reset_internal)
		(enable_any && mem_ready) |=> done && !enable_any)
		else begin
			error_count = error_count + 1;
			$display("[ERROR] %0t: done missing after mem_ready", $time);
		end

	a_done_cause: assert property (@(posedge clk) disable iff (reset_internal)
		done |-> $past(enable_any && mem_ready))
		else begin
			error_count = error_count + 1;
			$display("[ERROR] %0t: done without a completed bus cycle", $time);
		end

	a_one_completion: assert property (@(posedge clk) disable iff (reset_internal)
		(done || excep) |-> pending == 4'd1)
		else begin
			error_count = error_count + 1;
			$display("[ERROR] %0t: completion with %0d pending", $time, pending);
		end

	a_accept_when_empty: assert property (@(posedge clk) disable iff (reset_internal)
		accept_any |-> pending == 4'd0)
		else begin
			error_count = error_count + 1;
			$display("[ERROR] %0t: request accepted with %0d pending", $time, pending);
		end

	// Busy from the cycle after acceptance through the completion cycle
	a_busy_window: assert property (@(posedge clk) disable iff (reset_internal)
		busy == (pending != 4'd0))
		else begin
			error_count = error_count + 1;
			$display("[ERROR] %0t: busy=%b with %0d pending", $time, busy, pending);
		end

	task automatic run_request();
		logic [31:0] bits;
		logic [1:0] delay;
		logic [1:0] wait_cnt;
		logic strobe_again;
		logic finished;
		int cycles;
		draw_bits(2, bits);
		cur_size = rv_mem_pkg::access_size_t'((bits[1:0] == 2'd0) ? 2'd1 : bits[1:0]);
		draw_bits(32, cur_addr);
		draw_bits(1, bits);
		cur_load = bits[0];
		draw_bits(1, bits);
		cur_unsigned = bits[0];
		draw_bits(1, bits);
		cur_be = bits[0];
		draw_bits(32, cur_data);
		draw_bits(32, cur_word);
		draw_bits(2, bits);
		delay = bits[1:0];
		draw_bits(1, bits);
		strobe_again = bits[0];
		req_size = cur_size;
		req_addr = cur_addr;
		req_load = cur_load;
		req_unsigned = cur_unsigned;
		big_endian = cur_be;
		req_store_data = cur_data;
		req_valid = 1'b1;
		cycles = 0;
		wait_cnt = 2'd0;
		finished = 1'b0;
		while (!finished && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			#DRIVE_DELAY;
			cycles++;
			req_valid = 1'b0;
			if (mem_ready) begin
				mem_ready = 1'b0;
				mem_out = 32'h0;
			end else if (enable_any) begin
				if (wait_cnt == delay) begin
					mem_ready = 1'b1;
					mem_out = cur_word;
				end else begin
					wait_cnt++;
				end
			end
			if (done || excep) begin
				finished = 1'b1;
			end else if (strobe_again && cycles == 1) begin
				// Second strobe with a different address must be dropped
				req_valid = 1'b1;
				req_addr = ~cur_addr;
			end
		end
		if (!finished) begin
			timeout_count++;
			$display("Timeout: request %0d got neither done nor excep", issued);
		end
	endtask

	initial begin
		reset_internal = 1'b1;
		req_valid = 1'b0;
		req_load = 1'b0;
		req_unsigned = 1'b0;
		req_size = rv_mem_pkg::SIZE_WORD;
		req_addr = 32'h0;
		req_store_data = 32'h0;
		big_endian = 1'b0;
		mem_out = 32'h0;
		mem_ready = 1'b0;
		lfsr_state = LFSR_SEED;
		error_count = 0;
		timeout_count = 0;
		issued = 0;
		repeat (10) @(posedge clk);
		#DRIVE_DELAY;
		reset_internal = 1'b0;
		while (issued < NUM_REQUESTS && timeout_count == 0) begin
			@(posedge clk);
			#DRIVE_DELAY;
			run_request();
			issued++;
		end
		repeat (3) @(posedge clk);
		$display("Summary: %0d requests, %0d errors, %0d timeouts", issued, error_count,
			timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* mem_access_unit.sv */
`timescale 1ns/1ps

module mem_access_unit (
	input logic clk,
	input logic reset_internal,

	// Request side
	input logic req_valid,
	input logic req_load,
	input logic req_unsigned,
	input rv_mem_pkg::access_size_t req_size,
	input rv_mem_pkg::word_t req_addr,
	input rv_mem_pkg::word_t req_store_data,
	input logic big_endian,
	output logic busy,
	output logic done,
	output rv_mem_pkg::word_t load_data,
	output logic excep,
	output rv_trap_pkg::excep_code_t excep_code,

	// Memory side
	output rv_mem_pkg::word_t addr,
	output rv_mem_pkg::access_size_t data_size,
	output logic mem_read_enable,
	output logic mem_write_enable,
	output rv_mem_pkg::word_t mem_in,
	input rv_mem_pkg::word_t mem_out,
	input logic mem_ready
);

	mem_req_if u_req ();

	access_sequencer u_access_sequencer (
		.clk(clk),
		.reset_internal(reset_internal),
		.req_valid(req_valid),
		.req_load(req_load),
		.req_unsigned(req_unsigned),
		.req_size(req_size),
		.req_addr(req_addr),
		.req_store_data(req_store_data),
		.big_endian(big_endian),
		.mem_ready(mem_ready),
		.req(u_req.owner),
		.addr(addr),
		.data_size(data_size),
		.mem_read_enable(mem_read_enable),
		.mem_write_enable(mem_write_enable),
		.busy(busy),
		.done(done),
		.excep(excep),
		.excep_code(excep_code)
	);

	store_formatter u_store_formatter (
		.req(u_req.reader),
		.mem_write_enable(mem_write_enable),
		.mem_in(mem_in)
	);

	load_extractor u_load_extractor (
		.clk(clk),
		.reset_internal(reset_internal),
		.req(u_req.reader),
		.mem_read_enable(mem_read_enable),
		.mem_ready(mem_ready),
		.mem_out(mem_out),
		.load_data(load_data)
	);

endmodule

/* load_extractor.sv */
`timescale 1ns/1ps

module load_extractor (
	input logic clk,
	input logic reset_internal,
	mem_req_if.reader req,
	input logic mem_read_enable,
	input logic mem_ready,
	input rv_mem_pkg::word_t mem_out,
	output rv_mem_pkg::word_t load_data
);

	localparam int XLEN = rv_mem_pkg::XLEN;
	localparam int BYTE_W = rv_mem_pkg::BYTE_W;
	localparam int HALF_W = rv_mem_pkg::HALF_W;

	rv_mem_pkg::word_t shifted;
	rv_mem_pkg::word_t swapped;
	rv_mem_pkg::word_t result;
	logic [BYTE_W-1:0] byte_val;
	logic [HALF_W-1:0] half_raw;
	logic [HALF_W-1:0] half_val;
	logic sign;
	logic capture;

	// Offset 0 is the top lane, so shift the wanted lane up
	assign shifted = mem_out << (BYTE_W * req.addr[1:0]);
	assign swapped = rv_mem_pkg::byte_reverse(mem_out);

	assign byte_val = shifted[XLEN-1 -: BYTE_W];
	assign half_raw = shifted[XLEN-1 -: HALF_W];
	assign half_val = req.big_endian ? {half_raw[BYTE_W-1:0], half_raw[HALF_W-1 -: BYTE_W]}
		: half_raw;

	always_comb begin
		sign = 1'b0;
		case (req.size)
			rv_mem_pkg::SIZE_BYTE: begin
				sign = !req.is_unsigned && byte_val[BYTE_W-1];
				result = {{(XLEN-BYTE_W){sign}}, byte_val};
			end
			rv_mem_pkg::SIZE_HALF: begin
				sign = !req.is_unsigned && half_val[HALF_W-1];
				result = {{(XLEN-HALF_W){sign}}, half_val};
			end
			rv_mem_pkg::SIZE_WORD:
				result = req.big_endian ? swapped : mem_out;
			default:
				result = '0;
		endcase
	end

	assign capture = mem_read_enable && mem_ready;

	// Ready in the same cycle as done
	always_ff @(posedge clk or posedge reset_internal) begin
		if (reset_internal)
			load_data <= '0;
		else if (capture)
			load_data <= result;
	end

	// Misaligned halves must have been trapped before the bus
	a_half_even: assert property (@(posedge clk) disable iff (reset_internal)
		(capture && req.size == rv_mem_pkg::SIZE_HALF) |-> !req.addr[0])
		else $error("half load reached the bus with an odd offset");

endmodule

/* store_formatter.sv */
`timescale 1ns/1ps

module store_formatter (
	mem_req_if.reader req,
	input logic mem_write_enable,
	output rv_mem_pkg::word_t mem_in
);

	localparam int XLEN = rv_mem_pkg::XLEN;
	localparam int BYTE_W = rv_mem_pkg::BYTE_W;
	localparam int HALF_W = rv_mem_pkg::HALF_W;

	rv_mem_pkg::word_t swapped;

	assign swapped = rv_mem_pkg::byte_reverse(req.store_data);

	// Data sits in the upper lanes, unused lanes stay zero
	always_comb begin
		mem_in = '0;
		if (mem_write_enable) begin
			case (req.size)
				rv_mem_pkg::SIZE_BYTE:
					mem_in[XLEN-1 -: BYTE_W] = req.store_data[BYTE_W-1:0];
				rv_mem_pkg::SIZE_HALF:
					if (req.big_endian)
						mem_in[XLEN-1 -: HALF_W] = swapped[XLEN-1 -: HALF_W];
					else
						mem_in[XLEN-1 -: HALF_W] = req.store_data[HALF_W-1:0];
				rv_mem_pkg::SIZE_WORD:
					mem_in = req.big_endian ? swapped : req.store_data;
				default:
					mem_in = '0;
			endcase
		end
	end

endmodule

/* access_sequencer.sv */
`timescale 1ns/1ps

module access_sequencer (
	input logic clk,
	input logic reset_internal,
	input logic req_valid,
	input logic req_load,
	input logic req_unsigned,
	input rv_mem_pkg::access_size_t req_size,
	input rv_mem_pkg::word_t req_addr,
	input rv_mem_pkg::word_t req_store_data,
	input logic big_endian,
	input logic mem_ready,
	mem_req_if.owner req,
	output rv_mem_pkg::word_t addr,
	output rv_mem_pkg::access_size_t data_size,
	output logic mem_read_enable,
	output logic mem_write_enable,
	output logic busy,
	output logic done,
	output logic excep,
	output rv_trap_pkg::excep_code_t excep_code
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_FINISH
	} state_t;

	state_t state;
	state_t state_next;
	logic accept;
	logic misaligned;
	logic trap_q;

	// Strobes that arrive while busy are dropped here
	assign accept = req_valid && (state == ST_IDLE);

	always_comb begin
		case (req_size)
			rv_mem_pkg::SIZE_HALF:
				misaligned = req_addr[0];
			rv_mem_pkg::SIZE_WORD:
				misaligned = |req_addr[1:0];
			default:
				misaligned = 1'b0;
		endcase
	end

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE:
				if (req_valid)
					state_next = misaligned ? ST_FINISH : ST_ACCESS;
			ST_ACCESS:
				if (mem_ready)
					state_next = ST_FINISH;
			default:
				state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset_internal) begin
		if (reset_internal) begin
			state <= ST_IDLE;
			trap_q <= 1'b0;
			excep_code <= '0;
		end else begin
			state <= state_next;
			if (accept) begin
				trap_q <= misaligned;
				excep_code <= req_load ? rv_trap_pkg::EXC_LOAD_MISALIGNED
					: rv_trap_pkg::EXC_STORE_MISALIGNED;
			end
		end
	end

	always_ff @(posedge clk or posedge reset_internal) begin
		if (reset_internal) begin
			req.addr <= '0;
			req.size <= rv_mem_pkg::SIZE_WORD;
			req.is_load <= 1'b0;
			req.is_unsigned <= 1'b0;
			req.big_endian <= 1'b0;
		end else if (accept) begin
			req.addr <= req_addr;
			req.size <= req_size;
			req.is_load <= req_load;
			req.is_unsigned <= req_unsigned;
			req.big_endian <= big_endian;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			req.store_data <= req_store_data;
	end

	// Bus side holds steady through wait states
	assign addr = req.addr;
	assign data_size = req.size;
	assign mem_read_enable = (state == ST_ACCESS) && req.is_load;
	assign mem_write_enable = (state == ST_ACCESS) && !req.is_load;

	assign busy = (state != ST_IDLE);
	assign done = (state == ST_FINISH) && !trap_q;
	assign excep = (state == ST_FINISH) && trap_q;

	// Misaligned requests never reach the bus
	a_enable_aligned: assert property (@(posedge clk) disable iff (reset_internal)
		(mem_read_enable || mem_write_enable)
			|-> !(req.size == rv_mem_pkg::SIZE_HALF && req.addr[0])
			&& !(req.size == rv_mem_pkg::SIZE_WORD && req.addr[1:0] != 2'b00))
		else $error("misaligned request reached the bus");

	a_excep_timing: assert property (@(posedge clk) disable iff (reset_internal)
		excep |-> $past(accept))
		else $error("excep without an accepted request one cycle before");

endmodule

/* mem_req_if.sv */
`timescale 1ns/1ps

// Request held for the whole access
interface mem_req_if;

	rv_mem_pkg::word_t addr;
	rv_mem_pkg::access_size_t size;
	logic is_load;
	logic is_unsigned;
	rv_mem_pkg::word_t store_data;
	logic big_endian;

	modport owner (
		output addr,
		output size,
		output is_load,
		output is_unsigned,
		output store_data,
		output big_endian
	);

	modport reader (
		input addr,
		input size,
		input is_load,
		input is_unsigned,
		input store_data,
		input big_endian
	);

endinterface

/* rv_trap_pkg.sv */
package rv_trap_pkg;

	// Exception cause as written to mcause
	typedef logic [3:0] excep_code_t;

	localparam excep_code_t EXC_LOAD_MISALIGNED = 4'd4;
	localparam excep_code_t EXC_STORE_MISALIGNED = 4'd6;

endpackage

/* rv_mem_pkg.sv */
package rv_mem_pkg;

	localparam int XLEN = 32;
	localparam int BYTE_W = 8;
	localparam int HALF_W = 2 * BYTE_W;
	localparam int NUM_LANES = XLEN / BYTE_W;

	typedef logic [XLEN-1:0] word_t;

	// Size codes as seen on the data bus, 0 is not used
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd1,
		SIZE_HALF = 2'd2,
		SIZE_WORD = 2'd3
	} access_size_t;

	// Lane 0 swaps with the top lane and so on
	function automatic word_t byte_reverse(input word_t data);
		word_t swapped;
		for (int i = 0; i < NUM_LANES; i++) begin
			swapped[i*BYTE_W +: BYTE_W] = data[(NUM_LANES-1-i)*BYTE_W +: BYTE_W];
		end
		return swapped;
	endfunction

endpackage
